/* design/prep_defs.svh */
`ifndef PREP_DEFS_SVH
`define PREP_DEFS_SVH

// ******************************
// data path widths
// ******************************

// one sample is one beat
`define PREP_DATA_W 128
// byte address width
`define PREP_ADDR_W 32

// ******************************
// burst shape and address ring
// ******************************

// beats per burst, awlen is this minus one
`define PREP_BURST_LEN 8
// 128-bit beat
`define PREP_BEAT_BYTES 16
// ring start
`define PREP_INIT_ADDR 32'h0000_0000
// ring end, exclusive
`define PREP_END_ADDR 16384

// completed bursts per frame_done pulse
`define PREP_FRAME_BURSTS 16

// sample buffer and outstanding address queue
`define PREP_SAMPLE_DEPTH 32
`define PREP_OUTST_DEPTH 4

`endif

/* design/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  // id and length field widths
  localparam int ID_W = 4;
  localparam int LEN_W = 8;

  // single fixed transaction id, all bursts in order
  localparam logic [ID_W-1:0] AWID_VAL = 4'd1;

  // awburst encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // bresp codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // awsize, log2 of bytes per beat
  typedef enum logic [2:0] {
    SIZE_1B   = 3'd0,
    SIZE_2B   = 3'd1,
    SIZE_4B   = 3'd2,
    SIZE_8B   = 3'd3,
    SIZE_16B  = 3'd4,
    SIZE_32B  = 3'd5,
    SIZE_64B  = 3'd6,
    SIZE_128B = 3'd7
  } size_e;

endpackage

`default_nettype wire

/* design/prep_pkg.sv */
`default_nettype none

`include "prep_defs.svh"

package prep_pkg;

  // one sample, also one write beat
  typedef logic [`PREP_DATA_W-1:0] sample_t;

  // byte address on the write bus
  typedef logic [`PREP_ADDR_W-1:0] addr_t;

  // sticky error report
  // addr and resp hold the first failing burst only
  typedef struct packed {
    logic           err;
    addr_t          addr;
    axi_pkg::resp_e resp;
  } err_status_t;

endpackage

`default_nettype wire

/* design/axi_wr_if.sv */
`default_nettype none

`include "prep_defs.svh"

interface axi_wr_if;

  // ******************************
  // write address channel
  // ******************************
  logic                         awvalid;
  logic                         awready;
  prep_pkg::addr_t              awaddr;
  logic [axi_pkg::LEN_W-1:0]    awlen;
  axi_pkg::size_e               awsize;
  axi_pkg::burst_e              awburst;
  logic [axi_pkg::ID_W-1:0]     awid;

  // ******************************
  // write data channel
  // ******************************
  logic                         wvalid;
  logic                         wready;
  prep_pkg::sample_t            wdata;
  logic [`PREP_DATA_W/8-1:0]    wstrb;
  logic                         wlast;

  // ******************************
  // write response channel
  // ******************************
  logic                         bvalid;
  logic                         bready;
  axi_pkg::resp_e               bresp;
  logic [axi_pkg::ID_W-1:0]     bid;

  // address phase owner
  modport addr_mp (output awvalid, awaddr, awlen, awsize, awburst, awid, input awready);

  // data phase owner
  modport data_mp (output wvalid, wdata, wstrb, wlast, input wready);

  // response owner
  modport resp_mp (output bready, input bvalid, bresp, bid);

  // passive view, burst end and response handshakes
  modport mon_mp (input wvalid, wready, wlast, bvalid, bready);

endinterface

`default_nettype wire

/* design/sample_fifo.sv */
`default_nettype none

module sample_fifo #(
  parameter type payload_t = logic,
  // power of two, at least 2
  parameter int  DEPTH     = 4
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         push,
  input  wire payload_t                     push_data,
  input  wire logic                         pop,
  output payload_t                          head,
  output logic                              full,
  output logic                              empty,
  output logic [$clog2(DEPTH+1)-1:0]        count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry storage
  payload_t             mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic                 do_push;
  logic                 do_pop;

  // push while full is dropped
  // the caller flags a dropped push
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ******************************
  // pointers and occupancy
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // both at once leaves the level alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest entry always on head
  assign head  = mem[rd_ptr];
  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

endmodule

`default_nettype wire

/* design/burst_planner.sv */
`default_nettype none

`include "prep_defs.svh"

module burst_planner (
  input  wire logic                                    clk,
  input  wire logic                                    rst_n,
  input  wire logic [$clog2(`PREP_SAMPLE_DEPTH+1)-1:0] fifo_count,
  input  wire logic                                    outst_full,
  axi_wr_if.addr_mp                                    bus,
  axi_wr_if.mon_mp                                     mon,
  output logic                                         burst_go,
  output prep_pkg::addr_t                              burst_addr
);

  // bytes covered by one burst
  localparam prep_pkg::addr_t STEP = `PREP_BURST_LEN * `PREP_BEAT_BYTES;

  logic            awvalid_q;
  logic            data_active;
  logic            aw_hs;
  logic            w_done;
  logic            b_hs;
  logic            launch;
  prep_pkg::addr_t addr_q;
  prep_pkg::addr_t addr_step;

  assign aw_hs  = awvalid_q & bus.awready;
  assign w_done = mon.wvalid & mon.wready & mon.wlast;
  assign b_hs   = mon.bvalid & mon.bready;

  // ******************************
  // launch decision
  // ******************************
  // a full burst of samples waiting, data bus idle, a response slot free
  // a response this cycle frees its slot before the push lands
  assign launch = ~awvalid_q & ~data_active &
                  (fifo_count >= `PREP_BURST_LEN) & (~outst_full | b_hs);

  // data burst runs from our address handshake to the wlast beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_active <= 1'b0;
    end else if (aw_hs) begin
      data_active <= 1'b1;
    end else if (w_done) begin
      data_active <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awvalid_q <= 1'b0;
    end else if (launch) begin
      awvalid_q <= 1'b1;
    end else if (aw_hs) begin
      awvalid_q <= 1'b0;
    end
  end

  // ring address, wraps before the end
  assign addr_step = addr_q + STEP;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= `PREP_INIT_ADDR;
    end else if (aw_hs) begin
      addr_q <= (addr_step >= `PREP_END_ADDR) ? `PREP_INIT_ADDR : addr_step;
    end
  end

  // fixed burst shape
  assign bus.awvalid = awvalid_q;
  assign bus.awaddr  = addr_q;
  assign bus.awlen   = axi_pkg::LEN_W'(`PREP_BURST_LEN - 1);
  assign bus.awsize  = axi_pkg::SIZE_16B;
  assign bus.awburst = axi_pkg::BURST_INCR;
  assign bus.awid    = axi_pkg::AWID_VAL;

  // handoff to beat engine and response queue
  assign burst_go   = aw_hs;
  assign burst_addr = addr_q;

endmodule

`default_nettype wire

/* design/beat_engine.sv */
`default_nettype none

`include "prep_defs.svh"

module beat_engine (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              burst_go,
  input  wire prep_pkg::sample_t head,
  output logic                   pop,
  axi_wr_if.data_mp              bus
);

  localparam int BEAT_W = $clog2(`PREP_BURST_LEN);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`PREP_BURST_LEN - 1);

  logic              wvalid_q;
  logic [BEAT_W-1:0] beat_cnt;
  logic              w_hs;
  logic              last_beat;

  assign w_hs      = wvalid_q & bus.wready;
  assign last_beat = (beat_cnt == LAST_BEAT);

  // ******************************
  // beat sequencing
  // ******************************
  // wvalid one cycle after burst_go, down after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wvalid_q <= 1'b0;
      beat_cnt <= '0;
    end else if (burst_go) begin
      wvalid_q <= 1'b1;
      beat_cnt <= '0;
    end else if (w_hs) begin
      // counter wraps back to 0 on the last beat
      beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      if (last_beat) begin
        wvalid_q <= 1'b0;
      end
    end
  end

  // beat data straight off the fifo head
  assign bus.wvalid = wvalid_q;
  assign bus.wdata  = head;
  // full-width writes only
  assign bus.wstrb  = '1;
  // idle counter sits at 0, so wlast stays low between bursts
  assign bus.wlast  = last_beat;

  // each accepted beat consumes one sample
  assign pop = w_hs;

endmodule

`default_nettype wire

/* design/resp_tracker.sv */
`default_nettype none

`include "prep_defs.svh"

module resp_tracker (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                burst_go,
  input  wire prep_pkg::addr_t     burst_addr,
  axi_wr_if.resp_mp                bus,
  output logic                     outst_full,
  output logic                     frame_done,
  output prep_pkg::err_status_t    status
);

  localparam int FRAME_W = $clog2(`PREP_FRAME_BURSTS);

  logic                bready_q;
  logic                b_hs;
  logic                outst_empty;
  prep_pkg::addr_t     oldest_addr;
  logic [FRAME_W-1:0]  frame_cnt;

  // ready level, low only in reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bready_q <= 1'b0;
    end else begin
      bready_q <= 1'b1;
    end
  end

  assign bus.bready = bready_q;
  // stray response with nothing queued is not retired
  assign b_hs = bus.bvalid & bready_q & ~outst_empty;

  // ******************************
  // outstanding burst addresses
  // ******************************
  // in-order responses, head is the burst being answered
  sample_fifo #(
    .payload_t (prep_pkg::addr_t),
    .DEPTH     (`PREP_OUTST_DEPTH)
  ) outst_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (burst_go),
    .push_data (burst_addr),
    .pop       (b_hs),
    .head      (oldest_addr),
    .full      (outst_full),
    .empty     (outst_empty),
    .count     ()
  );

  // frame pulse the cycle after the closing response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= b_hs & (frame_cnt == FRAME_W'(`PREP_FRAME_BURSTS - 1));
      if (b_hs) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // first non-okay response wins, sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status <= '0;
    end else if (b_hs && !status.err && bus.bresp != axi_pkg::RESP_OKAY) begin
      status.err  <= 1'b1;
      status.addr <= oldest_addr;
      status.resp <= bus.bresp;
    end
  end

endmodule

`default_nettype wire

/* design/prep_axi_wr_top.sv */
`default_nettype none

`include "prep_defs.svh"

module prep_axi_wr_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  // sample stream
  input  wire logic                          sample_in_valid,
  input  wire logic [`PREP_DATA_W-1:0]       sample_in_data,
  output logic                               sample_in_ready,
  // write address
  output logic                               awvalid,
  input  wire logic                          awready,
  output logic [`PREP_ADDR_W-1:0]            awaddr,
  output logic [axi_pkg::LEN_W-1:0]          awlen,
  output logic [2:0]                         awsize,
  output logic [1:0]                         awburst,
  output logic [axi_pkg::ID_W-1:0]           awid,
  // write data
  output logic                               wvalid,
  input  wire logic                          wready,
  output logic [`PREP_DATA_W-1:0]            wdata,
  output logic [`PREP_DATA_W/8-1:0]          wstrb,
  output logic                               wlast,
  // write response
  input  wire logic                          bvalid,
  output logic                               bready,
  input  wire logic [1:0]                    bresp,
  input  wire logic [axi_pkg::ID_W-1:0]      bid,
  // status
  output logic                               frame_done,
  output logic                               resp_error,
  output logic [`PREP_ADDR_W-1:0]            err_addr,
  output logic                               overflow
);

  axi_wr_if axi_bus ();

  logic                                   sample_full;
  logic                                   sample_pop;
  prep_pkg::sample_t                      sample_head;
  logic [$clog2(`PREP_SAMPLE_DEPTH+1)-1:0] sample_count;
  logic                                   outst_full;
  logic                                   burst_go;
  prep_pkg::addr_t                        burst_addr;
  prep_pkg::err_status_t                  status;

  // ******************************
  // sample buffer
  // ******************************
  assign sample_in_ready = ~sample_full;

  sample_fifo #(
    .payload_t (prep_pkg::sample_t),
    .DEPTH     (`PREP_SAMPLE_DEPTH)
  ) sample_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (sample_in_valid),
    .push_data (sample_in_data),
    .pop       (sample_pop),
    .head      (sample_head),
    .full      (sample_full),
    .empty     (),
    .count     (sample_count)
  );

  // sample offered while full is lost
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (sample_in_valid && sample_full) begin
      overflow <= 1'b1;
    end
  end

  // ******************************
  // burst pipeline
  // ******************************
  burst_planner burst_planner_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_count (sample_count),
    .outst_full (outst_full),
    .bus        (axi_bus.addr_mp),
    .mon        (axi_bus.mon_mp),
    .burst_go   (burst_go),
    .burst_addr (burst_addr)
  );

  beat_engine beat_engine_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .burst_go (burst_go),
    .head     (sample_head),
    .pop      (sample_pop),
    .bus      (axi_bus.data_mp)
  );

  resp_tracker resp_tracker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .burst_go   (burst_go),
    .burst_addr (burst_addr),
    .bus        (axi_bus.resp_mp),
    .outst_full (outst_full),
    .frame_done (frame_done),
    .status     (status)
  );

  // interface out to the pins
  assign awvalid = axi_bus.awvalid;
  assign awaddr  = axi_bus.awaddr;
  assign awlen   = axi_bus.awlen;
  assign awsize  = axi_bus.awsize;
  assign awburst = axi_bus.awburst;
  assign awid    = axi_bus.awid;
  assign wvalid  = axi_bus.wvalid;
  assign wdata   = axi_bus.wdata;
  assign wstrb   = axi_bus.wstrb;
  assign wlast   = axi_bus.wlast;
  assign bready  = axi_bus.bready;

  // pins into the interface
  assign axi_bus.awready = awready;
  assign axi_bus.wready  = wready;
  assign axi_bus.bvalid  = bvalid;
  assign axi_bus.bresp   = axi_pkg::resp_e'(bresp);
  assign axi_bus.bid     = bid;

  // error report, response code kept internally
  assign resp_error = status.err;
  assign err_addr   = status.addr;

endmodule

`default_nettype wire

/* testbench/prep_assertions.sv */
`default_nettype none

module prep_assertions (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic awvalid,
  input wire logic awready,
  input wire logic [31:0] awaddr,
  input wire logic wvalid,
  input wire logic wready,
  input wire logic [127:0] wdata,
  input wire logic wlast
);

  // ******************************
  // protocol side state
  // ******************************
  // beat position inside the current burst
  logic [2:0] beat_pos;
  // address handshakes not yet closed by a wlast beat
  int unsigned aw_open;
  // failed assertions so far
  int unsigned fail_cnt = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_pos <= '0;
      aw_open  <= 0;
    end else begin
      if (wvalid && wready) begin
        beat_pos <= beat_pos + 3'd1;
      end
      case ({awvalid && awready, wvalid && wready && wlast})
        2'b10:   aw_open <= aw_open + 1;
        2'b01:   aw_open <= aw_open - 1;
        default: aw_open <= aw_open;
      endcase
    end
  end

  // address held steady while stalled
  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      fail_cnt++;
      $error("awvalid or awaddr changed before awready");
    end

  // data beat held steady while stalled
  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else begin
      fail_cnt++;
      $error("wvalid or beat payload changed before wready");
    end

  // wlast only on the eighth beat
  w_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && wready |-> (wlast == (beat_pos == 3'd7)))
    else begin
      fail_cnt++;
      $error("wlast not on the eighth beat");
    end

  // data needs an address phase first
  w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> aw_open != 0)
    else begin
      fail_cnt++;
      $error("wvalid without a preceding address handshake");
    end

endmodule

`default_nettype wire

/* testbench/prep_checker.sv */
`default_nettype none

`include "prep_defs.svh"

module prep_checker #(
  // responses before the final checks run
  parameter int TOTAL_BURSTS = 144
) (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         sample_in_valid,
  input  wire logic [127:0] sample_in_data,
  input  wire logic         sample_in_ready,
  input  wire logic         awvalid,
  input  wire logic         awready,
  input  wire logic [31:0]  awaddr,
  input  wire logic [7:0]   awlen,
  input  wire logic [2:0]   awsize,
  input  wire logic [1:0]   awburst,
  input  wire logic [3:0]   awid,
  input  wire logic         wvalid,
  input  wire logic         wready,
  input  wire logic [127:0] wdata,
  input  wire logic [15:0]  wstrb,
  input  wire logic         wlast,
  input  wire logic         bvalid,
  input  wire logic         bready,
  input  wire logic         frame_done,
  input  wire logic         resp_error,
  input  wire logic [31:0]  err_addr,
  input  wire logic         overflow,
  output logic              done,
  output int                mismatch_cnt,
  output int                other_cnt
);

  localparam int STEP = `PREP_BURST_LEN * `PREP_BEAT_BYTES;
  localparam int RING = (`PREP_END_ADDR - `PREP_INIT_ADDR) / STEP;

  logic [127:0] acc_q[$];
  logic [127:0] exp_sample;
  int aw_n;
  int beat_n;
  int b_n;
  int frame_n;
  int settle;

  // ******************************
  // reference model
  // ******************************
  // ring of 128-byte bursts
  function automatic logic [31:0] expected_addr(input int burst_idx);
    return `PREP_INIT_ADDR + (burst_idx % RING) * STEP;
  endfunction

  // samples are numbered in acceptance order
  function automatic logic [127:0] expected_data(input int beat_idx);
    return 128'(beat_idx);
  endfunction

  task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %0h actual %0h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  initial begin
    done = 1'b0;
    mismatch_cnt = 0;
    other_cnt = 0;
    aw_n = 0;
    beat_n = 0;
    b_n = 0;
    frame_n = 0;
    settle = 0;
  end

  // checks run at the falling edge
  always @(negedge clk) begin
    if (rst_n && !done) begin
      if (sample_in_valid && sample_in_ready) begin
        acc_q.push_back(sample_in_data);
      end
      if (awvalid && awready) begin
        compare("awaddr", expected_addr(aw_n), awaddr);
        compare("awlen", 7, awlen);
        compare("awburst", 1, awburst);
        compare("awsize", 4, awsize);
        compare("awid", axi_pkg::AWID_VAL, awid);
        aw_n++;
      end
      if (wvalid && wready) begin
        if (acc_q.size() == 0) begin
          $display("write beat %0d arrived with no accepted sample left", beat_n);
          other_cnt++;
        end else begin
          exp_sample = acc_q.pop_front();
          compare("wdata_vs_accepted", exp_sample, wdata);
        end
        compare("wdata", expected_data(beat_n), wdata);
        compare("wstrb", 16'hffff, wstrb);
        compare("wlast", (beat_n % 8) == 7, wlast);
        beat_n++;
      end
      if (bvalid && bready) begin
        b_n++;
      end
      if (frame_done) begin
        frame_n++;
      end
      // frame pulse trails the last response by a cycle
      if (b_n >= TOTAL_BURSTS) begin
        settle++;
        if (settle == 3) begin
          compare("frame_count", b_n / `PREP_FRAME_BURSTS, frame_n);
          compare("resp_error", 1, resp_error);
          compare("err_addr", expected_addr(5), err_addr);
          compare("overflow", 1, overflow);
          if (aw_n <= RING) begin
            $display("only %0d bursts seen, address ring never wrapped", aw_n);
            other_cnt++;
          end
          done = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/prep_tb.sv */
`default_nettype none

module prep_tb;

  localparam int TOTAL_BURSTS = 144;
  localparam int TIMEOUT_CYCLES = 40000;

  logic         clk;
  logic         rst_n;
  logic         sample_in_valid;
  logic [127:0] sample_in_data;
  logic         sample_in_ready;
  logic         awvalid;
  logic         awready;
  logic [31:0]  awaddr;
  logic [7:0]   awlen;
  logic [2:0]   awsize;
  logic [1:0]   awburst;
  logic [3:0]   awid;
  logic         wvalid;
  logic         wready;
  logic [127:0] wdata;
  logic [15:0]  wstrb;
  logic         wlast;
  logic         bvalid;
  logic         bready;
  logic [1:0]   bresp;
  logic [3:0]   bid;
  logic         frame_done;
  logic         resp_error;
  logic [31:0]  err_addr;
  logic         overflow;
  logic         chk_done;
  int           mismatch_cnt;
  int           other_cnt;

  prep_axi_wr_top dut_i (.*);

  prep_checker #(.TOTAL_BURSTS(TOTAL_BURSTS)) chk_i (
    .clk(clk), .rst_n(rst_n),
    .sample_in_valid(sample_in_valid), .sample_in_data(sample_in_data),
    .sample_in_ready(sample_in_ready),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awlen(awlen),
    .awsize(awsize), .awburst(awburst), .awid(awid),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
    .bvalid(bvalid), .bready(bready), .frame_done(frame_done),
    .resp_error(resp_error), .err_addr(err_addr), .overflow(overflow),
    .done(chk_done), .mismatch_cnt(mismatch_cnt), .other_cnt(other_cnt)
  );

  bind prep_axi_wr_top prep_assertions asrt_i (
    .clk(clk), .rst_n(rst_n), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast)
  );

  // ******************************
  // clock and reset
  // ******************************
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  initial begin
    void'($urandom(32'h9f49));
    rst_n = 1'b0;
    sample_in_valid = 1'b0;
    sample_in_data = '0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = 2'b00;
    bid = 4'd1;
    repeat (16) @(posedge clk);
    #10 rst_n = 1'b1;
  end

  // ******************************
  // sample source
  // ******************************
  // value is the sequence number
  // next number only after acceptance
  initial begin : sample_source
    int seq;
    seq = 0;
    forever begin
      @(posedge clk);
      if (sample_in_valid && sample_in_ready) begin
        seq++;
      end
      #10;
      if (rst_n) begin
        sample_in_valid = ($urandom % 8) != 0;
        sample_in_data = 128'(seq);
      end
    end
  end

  // ******************************
  // memory side responder
  // ******************************
  initial begin : responder
    int aw_n;
    int pend_b;
    int b_idx;
    int b_delay;
    int stall_left;
    bit b_taken;
    aw_n = 0;
    pend_b = 0;
    b_idx = 0;
    b_delay = 0;
    stall_left = 0;
    forever begin
      @(posedge clk);
      b_taken = 1'b0;
      if (awvalid && awready) begin
        aw_n++;
        // long address stall fills the sample buffer
        if (aw_n == 20) begin
          stall_left = 300;
        end
      end
      if (wvalid && wready && wlast) begin
        pend_b++;
      end
      if (bvalid && bready) begin
        b_taken = 1'b1;
        b_idx++;
      end
      #10;
      if (rst_n) begin
        awready = (stall_left > 0) ? 1'b0 : (($urandom % 4) != 0);
        if (stall_left > 0) begin
          stall_left--;
        end
        wready = ($urandom % 4) != 0;
        if (b_taken) begin
          bvalid = 1'b0;
        end
        if (!bvalid && !b_taken && pend_b > 0) begin
          if (b_delay == 0) begin
            bvalid = 1'b1;
            // slverr on burst 5 only
            bresp = (b_idx == 5) ? 2'b10 : 2'b00;
            pend_b--;
            b_delay = $urandom % 4;
          end else begin
            b_delay--;
          end
        end
      end
    end
  end

  task automatic finish_run(input bit timed_out);
    int unsigned assert_cnt;
    assert_cnt = dut_i.asrt_i.fail_cnt;
    if (timed_out) begin
      $display("timeout: checker did not see %0d write responses", TOTAL_BURSTS);
    end
    $display("error counts: %0d mismatches, %0d other errors, %0d assertion failures, %0d timeouts",
             mismatch_cnt, other_cnt, assert_cnt, timed_out);
    if (!timed_out && mismatch_cnt == 0 && other_cnt == 0 && assert_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // bounded wait for the checker
  initial begin : run_control
    int cycles;
    cycles = 0;
    while (!chk_done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    finish_run(!chk_done);
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/axi_pkg.sv
design/prep_pkg.sv
design/axi_wr_if.sv
design/sample_fifo.sv
design/burst_planner.sv
design/beat_engine.sv
design/resp_tracker.sv
design/prep_axi_wr_top.sv
testbench/prep_assertions.sv
testbench/prep_checker.sv
testbench/prep_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= prep_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
